//--- rtl/isaPkg.sv
`default_nettype none

// MIPS32 instruction encoding used by the decoder
package isaPkg;

	////////////////////////////////////////
	// Field positions in the 32-bit word
	////////////////////////////////////////
	localparam int opcodeHi = 31;
	localparam int opcodeLo = 26;
	localparam int rsHi     = 25;
	localparam int rsLo     = 21;
	localparam int rtHi     = 20;
	localparam int rtLo     = 16;
	localparam int rdHi     = 15;
	localparam int rdLo     = 11;
	localparam int shamtHi  = 10;
	localparam int shamtLo  = 6;
	localparam int immHi    = 15;
	localparam int immLo    = 0;
	localparam int functHi  = 5;
	localparam int functLo  = 0;

	////////////////////////////////////////
	// Opcodes
	////////////////////////////////////////
	// Register forms, real op sits in funct
	localparam logic [5:0] opcodeSpecial = 6'h00;
	localparam logic [5:0] opAddi        = 6'h08;
	localparam logic [5:0] opAddiu       = 6'h09;
	localparam logic [5:0] opSlti        = 6'h0a;
	localparam logic [5:0] opSltiu       = 6'h0b;
	localparam logic [5:0] opAndi        = 6'h0c;
	localparam logic [5:0] opOri         = 6'h0d;
	localparam logic [5:0] opXori        = 6'h0e;
	localparam logic [5:0] opLui         = 6'h0f;

	////////////////////////////////////////
	// Funct codes under opcodeSpecial
	////////////////////////////////////////
	localparam logic [5:0] functSll  = 6'h00;
	localparam logic [5:0] functSrl  = 6'h02;
	localparam logic [5:0] functSra  = 6'h03;
	localparam logic [5:0] functSllv = 6'h04;
	localparam logic [5:0] functSrlv = 6'h06;
	localparam logic [5:0] functSrav = 6'h07;
	localparam logic [5:0] functAdd  = 6'h20;
	localparam logic [5:0] functAddu = 6'h21;
	localparam logic [5:0] functSub  = 6'h22;
	localparam logic [5:0] functSubu = 6'h23;
	localparam logic [5:0] functAnd  = 6'h24;
	localparam logic [5:0] functOr   = 6'h25;
	localparam logic [5:0] functXor  = 6'h26;
	localparam logic [5:0] functNor  = 6'h27;
	localparam logic [5:0] functSlt  = 6'h2a;
	localparam logic [5:0] functSltu = 6'h2b;

endpackage

`default_nettype wire

//--- rtl/aluPkg.sv
`default_nettype none

// ALU operations and the payloads carried between stages
package aluPkg;

	// Fixed by the instruction set
	localparam int dataWidth = 32;

	////////////////////////////////////////
	// ALU operation codes
	////////////////////////////////////////
	typedef enum logic [3:0] {
		aluAddu,
		aluSubu,
		aluAdd,
		aluSub,
		aluAnd,
		aluOr,
		aluXor,
		aluNor,
		// Signed or unsigned, picked by specialSign
		aluSlt,
		aluShiftL,
		aluShiftRL,
		aluShiftRA
	} aluOpE;

	////////////////////////////////////////
	// Stage payloads
	////////////////////////////////////////
	// Decode to ALU, 75 bits
	typedef struct packed {
		aluOpE                aluOp;
		logic                 specialSign;
		logic [dataWidth-1:0] operandA;
		logic [dataWidth-1:0] operandB;
		logic [4:0]           destReg;
		logic                 legal;
	} decodeBundleT;

	// ALU to retire
	typedef struct packed {
		logic [dataWidth-1:0] result;
		logic                 overflow;
		logic [4:0]           destReg;
		logic                 legal;
	} aluBundleT;

endpackage

`default_nettype wire

//--- rtl/pipeStage.sv
`timescale 1ns/1ps
`default_nettype none

// One-entry register slice with valid/ready on both sides
module pipeStage #(
	parameter type payloadT = logic
) (
	input  wire logic    clk,
	input  wire logic    rstN,
	// Upstream side
	input  wire logic    inValid,
	output logic         inReady,
	input  wire payloadT inData,
	// Downstream side
	output logic         outValid,
	input  wire logic    outReady,
	output payloadT      outData
);

	////////////////////////////////////////
	// Handshake
	////////////////////////////////////////
	// Free when empty or when the held item leaves this cycle
	assign inReady = !outValid || outReady;

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			outValid <= 1'b0;
		end else if (inReady) begin
			// Bubble in when nothing is offered
			outValid <= inValid;
		end
	end

	////////////////////////////////////////
	// Payload register
	////////////////////////////////////////
	// Only loads on an actual transfer
	always_ff @(posedge clk) begin
		if (inReady && inValid) begin
			outData <= inData;
		end
	end

	// Stalled item must not change or vanish
	holdWhileStalled: assert property (@(posedge clk) disable iff (!rstN)
		outValid && !outReady |=> outValid && $stable(outData))
		else $error("pipeStage: item changed while stalled");

endmodule

`default_nettype wire

//--- rtl/instrDecoder.sv
`timescale 1ns/1ps
`default_nettype none

// Maps an instruction word plus register values onto an ALU request
module instrDecoder import isaPkg::*, aluPkg::*; (
	input  wire logic [31:0]          instr,
	input  wire logic [dataWidth-1:0] rsValue,
	input  wire logic [dataWidth-1:0] rtValue,
	output aluOpE                     aluOp,
	output logic                      specialSign,
	output logic [dataWidth-1:0]      operandA,
	output logic [dataWidth-1:0]      operandB,
	output logic [4:0]                destReg,
	output logic                      legal
);

	logic [5:0]           opcode;
	logic [5:0]           funct;
	logic [4:0]           rtField;
	logic [4:0]           rdField;
	logic [4:0]           shamt;
	logic [15:0]          imm;
	logic [dataWidth-1:0] shamtExt;
	logic [dataWidth-1:0] immSext;
	logic [dataWidth-1:0] immZext;

	////////////////////////////////////////
	// Field split
	////////////////////////////////////////
	assign opcode   = instr[opcodeHi:opcodeLo];
	assign funct    = instr[functHi:functLo];
	assign rtField  = instr[rtHi:rtLo];
	assign rdField  = instr[rdHi:rdLo];
	assign shamt    = instr[shamtHi:shamtLo];
	assign imm      = instr[immHi:immLo];
	assign shamtExt = {{(dataWidth-5){1'b0}}, shamt};
	assign immSext  = {{(dataWidth-16){imm[15]}}, imm};
	assign immZext  = {{(dataWidth-16){1'b0}}, imm};

	////////////////////////////////////////
	// Operation select
	////////////////////////////////////////
	always_comb begin
		// Register-form defaults
		aluOp       = aluAddu;
		specialSign = 1'b0;
		operandA    = rsValue;
		operandB    = rtValue;
		destReg     = rdField;
		legal       = 1'b1;
		if (opcode == opcodeSpecial) begin
			case (funct)
				functAddu: aluOp = aluAddu;
				functSubu: aluOp = aluSubu;
				functAnd:  aluOp = aluAnd;
				functOr:   aluOp = aluOr;
				functXor:  aluOp = aluXor;
				functNor:  aluOp = aluNor;
				functSltu: aluOp = aluSlt;
				functAdd: begin
					aluOp       = aluAdd;
					specialSign = 1'b1;
				end
				functSub: begin
					aluOp       = aluSub;
					specialSign = 1'b1;
				end
				functSlt: begin
					aluOp       = aluSlt;
					specialSign = 1'b1;
				end
				// Fixed shifts take the amount from shamt
				functSll: begin
					aluOp    = aluShiftL;
					operandA = shamtExt;
				end
				functSrl: begin
					aluOp    = aluShiftRL;
					operandA = shamtExt;
				end
				functSra: begin
					aluOp    = aluShiftRA;
					operandA = shamtExt;
				end
				// Variable shifts keep rsValue as the amount
				functSllv: aluOp = aluShiftL;
				functSrlv: aluOp = aluShiftRL;
				functSrav: aluOp = aluShiftRA;
				default:   legal = 1'b0;
			endcase
		end else begin
			// Immediate forms write rt
			destReg  = rtField;
			operandB = immSext;
			case (opcode)
				opAddiu: aluOp = aluAddu;
				opSltiu: aluOp = aluSlt;
				opAddi: begin
					aluOp       = aluAdd;
					specialSign = 1'b1;
				end
				opSlti: begin
					aluOp       = aluSlt;
					specialSign = 1'b1;
				end
				// Logic immediates are zero-extended
				opAndi: begin
					aluOp    = aluAnd;
					operandB = immZext;
				end
				opOri: begin
					aluOp    = aluOr;
					operandB = immZext;
				end
				opXori: begin
					aluOp    = aluXor;
					operandB = immZext;
				end
				// lui as imm << 16
				opLui: begin
					aluOp    = aluShiftL;
					operandA = dataWidth'(16);
					operandB = immZext;
				end
				default: legal = 1'b0;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- rtl/alu.sv
`timescale 1ns/1ps
`default_nettype none

// Arithmetic-logic block, purely combinational
module alu import aluPkg::*; (
	input  wire logic [dataWidth-1:0] operandA,
	input  wire logic [dataWidth-1:0] operandB,
	input  wire aluOpE                aluOp,
	input  wire logic                 specialSign,
	output logic [dataWidth-1:0]      result,
	output logic                      overflow
);

	logic [4:0]         shiftAmt;
	logic [dataWidth:0] cmpA;
	logic [dataWidth:0] cmpB;
	logic [dataWidth:0] aExt;
	logic [dataWidth:0] bExt;
	logic [dataWidth:0] sumExt;

	// Only the low 5 bits count
	assign shiftAmt = operandA[4:0];

	// Compare operands, top bit kept only for signed compare
	assign cmpA = {specialSign & operandA[dataWidth-1], operandA};
	assign cmpB = {specialSign & operandB[dataWidth-1], operandB};

	////////////////////////////////////////
	// Signed add/sub with overflow
	////////////////////////////////////////
	assign aExt   = {operandA[dataWidth-1], operandA};
	assign bExt   = {operandB[dataWidth-1], operandB};
	assign sumExt = (aluOp == aluSub) ? aExt - bExt : aExt + bExt;
	// Top two bits disagree on signed overflow
	assign overflow = ((aluOp == aluAdd) || (aluOp == aluSub))
		&& (sumExt[dataWidth] != sumExt[dataWidth-1]);

	always_comb begin
		case (aluOp)
			aluAddu:    result = operandA + operandB;
			aluSubu:    result = operandA - operandB;
			aluAdd:     result = sumExt[dataWidth-1:0];
			aluSub:     result = sumExt[dataWidth-1:0];
			aluAnd:     result = operandA & operandB;
			aluOr:      result = operandA | operandB;
			aluXor:     result = operandA ^ operandB;
			aluNor:     result = ~(operandA | operandB);
			aluSlt:     result = ($signed(cmpA) < $signed(cmpB)) ? dataWidth'(1) : '0;
			aluShiftL:  result = operandB << shiftAmt;
			aluShiftRL: result = operandB >> shiftAmt;
			aluShiftRA: result = $signed(operandB) >>> shiftAmt;
			default:    result = '0;
		endcase
	end

	// Encodings 12..15 never leave the decoder
	always_comb begin
		if (!$isunknown(aluOp)) begin
			opDefined: assert final (aluOp inside {[aluAddu:aluShiftRA]})
				else $error("alu: undefined operation code %0d", aluOp);
		end
	end

endmodule

`default_nettype wire

//--- rtl/resultRetire.sv
`timescale 1ns/1ps
`default_nettype none

// Write-back decision and exception flags
module resultRetire import aluPkg::*; (
	input  wire logic [dataWidth-1:0] result,
	input  wire logic                 overflow,
	input  wire logic [4:0]           destReg,
	input  wire logic                 legal,
	output logic                      writeEn,
	output logic                      overflowExc,
	output logic                      illegalExc,
	output logic                      zero
);

	////////////////////////////////////////
	// Exceptions
	////////////////////////////////////////
	assign illegalExc = !legal;
	// Overflow only meaningful for a decoded op
	assign overflowExc = legal && overflow;

	////////////////////////////////////////
	// Write-back
	////////////////////////////////////////
	// Register zero is hardwired, never written
	assign writeEn = legal && !overflow && (destReg != 5'd0);

	// All-zero result
	assign zero = (result == '0);

	// An overflowing op must not reach the register file
	always_comb begin
		if (!$isunknown({writeEn, overflowExc})) begin
			noWriteOnOverflow: assert final (!(writeEn && overflowExc))
				else $error("resultRetire: write enabled on overflow");
		end
	end

endmodule

`default_nettype wire

//--- rtl/execUnit.sv
`timescale 1ns/1ps
`default_nettype none

// Execute unit: decode, register, ALU, register, retire
module execUnit import aluPkg::*; (
	input  wire logic                 clk,
	input  wire logic                 rstN,
	// Instruction in
	input  wire logic                 inValid,
	output logic                      inReady,
	input  wire logic [31:0]          instr,
	input  wire logic [dataWidth-1:0] rsValue,
	input  wire logic [dataWidth-1:0] rtValue,
	// Result out
	output logic                      outValid,
	input  wire logic                 outReady,
	output logic [dataWidth-1:0]      result,
	output logic [4:0]                destReg,
	output logic                      writeEn,
	output logic                      overflowExc,
	output logic                      illegalExc,
	output logic                      zero
);

	decodeBundleT decIn;
	decodeBundleT decOut;
	aluBundleT    aluIn;
	aluBundleT    aluOut;
	logic         decValid;
	logic         aluReady;
	logic         retWriteEn;
	logic         retOverflowExc;
	logic         retIllegalExc;

	////////////////////////////////////////
	// Decode, then first register
	////////////////////////////////////////
	instrDecoder decoder (
		.instr(instr),
		.rsValue(rsValue),
		.rtValue(rtValue),
		.aluOp(decIn.aluOp),
		.specialSign(decIn.specialSign),
		.operandA(decIn.operandA),
		.operandB(decIn.operandB),
		.destReg(decIn.destReg),
		.legal(decIn.legal)
	);

	pipeStage #(.payloadT(decodeBundleT)) decodeStage (
		.clk(clk),
		.rstN(rstN),
		.inValid(inValid),
		.inReady(inReady),
		.inData(decIn),
		.outValid(decValid),
		.outReady(aluReady),
		.outData(decOut)
	);

	////////////////////////////////////////
	// ALU, then second register
	////////////////////////////////////////
	alu aluCore (
		.operandA(decOut.operandA),
		.operandB(decOut.operandB),
		.aluOp(decOut.aluOp),
		.specialSign(decOut.specialSign),
		.result(aluIn.result),
		.overflow(aluIn.overflow)
	);

	// Destination and legality ride along
	assign aluIn.destReg = decOut.destReg;
	assign aluIn.legal   = decOut.legal;

	pipeStage #(.payloadT(aluBundleT)) aluStage (
		.clk(clk),
		.rstN(rstN),
		.inValid(decValid),
		.inReady(aluReady),
		.inData(aluIn),
		.outValid(outValid),
		.outReady(outReady),
		.outData(aluOut)
	);

	////////////////////////////////////////
	// Retire
	////////////////////////////////////////
	resultRetire retire (
		.result(aluOut.result),
		.overflow(aluOut.overflow),
		.destReg(aluOut.destReg),
		.legal(aluOut.legal),
		.writeEn(retWriteEn),
		.overflowExc(retOverflowExc),
		.illegalExc(retIllegalExc),
		.zero(zero)
	);

	assign result  = aluOut.result;
	assign destReg = aluOut.destReg;

	// Flags only count with a valid item
	assign writeEn     = outValid && retWriteEn;
	assign overflowExc = outValid && retOverflowExc;
	assign illegalExc  = outValid && retIllegalExc;

endmodule

`default_nettype wire

//--- verification/execUnitTb.sv
`timescale 1ns/1ps
`default_nettype none

// Vector-driven testbench for the execute unit
module execUnitTb;

	localparam int numVectors     = 31;
	localparam int wordsPerVector = 6;
	localparam int seedValue      = 89770;
	// Longest any single wait may last, in cycles
	localparam int waitLimit      = 200;

	logic        clk;
	logic        rstN;
	logic        inValid;
	logic        inReady;
	logic [31:0] instr;
	logic [31:0] rsValue;
	logic [31:0] rtValue;
	logic        outValid;
	logic        outReady;
	logic [31:0] result;
	logic [4:0]  destReg;
	logic        writeEn;
	logic        overflowExc;
	logic        illegalExc;
	logic        zero;

	// Six words per vector, column order as in the hex file
	logic [31:0] vecMem [0:numVectors*wordsPerVector-1];

	integer seed;
	integer readySeed;
	int     passCount;
	int     failCount;
	int     otherErrors;

	execUnit DUT (
		.clk(clk),
		.rstN(rstN),
		.inValid(inValid),
		.inReady(inReady),
		.instr(instr),
		.rsValue(rsValue),
		.rtValue(rtValue),
		.outValid(outValid),
		.outReady(outReady),
		.result(result),
		.destReg(destReg),
		.writeEn(writeEn),
		.overflowExc(overflowExc),
		.illegalExc(illegalExc),
		.zero(zero)
	);

	// 10 ns period
	always #5 clk = ~clk;

	////////////////////////////////////////
	// Helpers
	////////////////////////////////////////
	task automatic reportTimeout(input string what);
		$display("Timeout at %0t: %s", $time, what);
		otherErrors++;
	endtask

	// One output against its expected value, 1 on mismatch
	function automatic int checkValue(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected) begin
			$display("[FAIL] %0t %s expected %h got %h", $time, name, expected, actual);
			return 1;
		end
		return 0;
	endfunction

	task automatic checkItem(input int idx);
		int         base;
		int         errors;
		logic [3:0] flags;
		base   = idx * wordsPerVector;
		flags  = vecMem[base+5][3:0];
		errors = 0;
		// Result and destination carry no meaning on an illegal item
		if (!flags[1]) begin
			errors += checkValue("result", vecMem[base+3], result);
			errors += checkValue("destReg", vecMem[base+4], 32'(destReg));
			errors += checkValue("zero", 32'(flags[0]), 32'(zero));
		end
		errors += checkValue("writeEn", 32'(flags[3]), 32'(writeEn));
		errors += checkValue("overflowExc", 32'(flags[2]), 32'(overflowExc));
		errors += checkValue("illegalExc", 32'(flags[1]), 32'(illegalExc));
		if (errors == 0) begin
			passCount++;
			$display("Vector %0d instr %h ok", idx, vecMem[base]);
		end else begin
			failCount++;
			$display("Vector %0d instr %h failed, %0d mismatches", idx, vecMem[base], errors);
		end
	endtask

	////////////////////////////////////////
	// Driver
	////////////////////////////////////////
	task automatic sendVectors();
		int   gap;
		int   waited;
		int   base;
		logic accepted;
		for (int idx = 0; idx < numVectors; idx++) begin
			base = idx * wordsPerVector;
			gap  = int'({$random(seed)} % 32'd3);
			// Random bubble before the item
			if (gap > 0) begin
				inValid = 1'b0;
				repeat (gap) begin
					@(posedge clk);
					#1;
				end
			end
			inValid = 1'b1;
			instr   = vecMem[base];
			rsValue = vecMem[base+1];
			rtValue = vecMem[base+2];
			// Hold the item until the edge that takes it
			waited = 0;
			do begin
				// Ready has settled half a cycle before the edge
				@(negedge clk);
				accepted = inReady;
				@(posedge clk);
				waited++;
				if (!accepted && waited > waitLimit) begin
					reportTimeout("input side never accepted the item");
					return;
				end
			end while (!accepted);
			#1;
		end
		inValid = 1'b0;
	endtask

	////////////////////////////////////////
	// Monitor
	////////////////////////////////////////
	task automatic receiveVectors();
		int got;
		int idle;
		got  = 0;
		idle = 0;
		while (got < numVectors) begin
			// Random back-pressure
			outReady = (({$random(readySeed)} % 32'd4) != 32'd0);
			// Outputs are stable half a cycle before the edge that takes them
			@(negedge clk);
			if (outValid && outReady) begin
				checkItem(got);
				got++;
				idle = 0;
			end else begin
				if (!outValid && (writeEn || overflowExc || illegalExc)) begin
					$display("Flags raised at %0t while outValid is low", $time);
					otherErrors++;
				end
				idle++;
				if (idle > waitLimit) begin
					reportTimeout("output side went quiet before all vectors arrived");
					return;
				end
			end
			@(posedge clk);
			#1;
		end
		// Nothing may follow the last vector
		outReady = 1'b1;
		repeat (8) begin
			@(negedge clk);
			if (outValid) begin
				$display("Extra output at %0t after the last vector", $time);
				otherErrors++;
			end
		end
	endtask

	////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////
	initial begin
		clk         = 1'b0;
		rstN        = 1'b0;
		inValid     = 1'b0;
		instr       = '0;
		rsValue     = '0;
		rtValue     = '0;
		outReady    = 1'b0;
		seed        = seedValue;
		readySeed   = $random(seed);
		passCount   = 0;
		failCount   = 0;
		otherErrors = 0;
		$readmemh("verification/execVectors.hex", vecMem);
		// Reset held for five cycles
		repeat (5) @(posedge clk);
		#1;
		rstN = 1'b1;
		if (outValid || writeEn || overflowExc || illegalExc) begin
			$display("Output side active right after reset");
			otherErrors++;
		end
		fork
			sendVectors();
			receiveVectors();
		join
		$display("Vectors passed %0d, failed %0d, other errors %0d",
			passCount, failCount, otherErrors);
		if (failCount == 0 && otherErrors == 0 && passCount == numVectors) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- verification/execVectors.hex
// instr    rsValue  rtValue  result   destReg flags
// flags nibble: bit3 writeEn, bit2 overflowExc, bit1 illegalExc, bit0 zero
00221821 12345678 11111111 23456789 03 8 // addu
00221823 00000005 00000007 fffffffe 03 8 // subu
00221824 f0f0f0f0 ff00ff00 f000f000 03 8 // and
00221825 f0f0f0f0 0f0f0000 fffff0f0 03 8 // or
00221826 aaaaaaaa aaaaaaaa 00000000 03 9 // xor to zero
00221827 f0f0f0f0 0f0f0000 00000f0f 03 8 // nor
30228f0f ffffffff 00000000 00008f0f 02 8 // andi, zero-extended
34228000 00000001 00000000 00008001 02 8 // ori, zero-extended
3822ffff 0000ffff 00000000 00000000 02 9 // xori to zero
2422ffff 00000010 00000000 0000000f 02 8 // addiu, sign-extended
00221900 deadbeef 0000000f 000000f0 03 8 // sll 4
00221a02 deadbeef 80000000 00800000 03 8 // srl 8
00221a03 deadbeef 80000000 ff800000 03 8 // sra 8
00221804 00000021 00000003 00000006 03 8 // sllv by 33
00221806 0000003f 80000000 00000001 03 8 // srlv by 63
00221807 ffffffff 80000000 ffffffff 03 8 // srav by all ones
3c021234 ffffffff 00000000 12340000 02 8 // lui
0022182a ffffffff 00000001 00000001 03 8 // slt
0022182b ffffffff 00000001 00000000 03 9 // sltu
28220001 ffffffff 00000000 00000001 02 8 // slti
2c220001 ffffffff 00000000 00000000 02 9 // sltiu
00221820 7fffffff 00000001 80000000 03 4 // add overflow
00221821 7fffffff 00000001 80000000 03 8 // addu same operands
00221822 80000000 00000001 7fffffff 03 4 // sub overflow
00221823 80000000 00000001 7fffffff 03 8 // subu same operands
20227fff 7fffffff 00000000 80007ffe 02 4 // addi overflow
24227fff 7fffffff 00000000 80007ffe 02 8 // addiu same operands
00221820 ffffffff 00000001 00000000 03 9 // add without overflow
00220021 00000001 00000002 00000003 00 0 // addu into r0
fc221234 00000001 00000002 00000000 00 2 // undefined opcode
00221801 00000001 00000002 00000000 00 2 // undefined funct

//--- files.f
rtl/isaPkg.sv
rtl/aluPkg.sv
rtl/pipeStage.sv
rtl/instrDecoder.sv
rtl/alu.sv
rtl/resultRetire.sv
rtl/execUnit.sv
verification/execUnitTb.sv

//--- Makefile
# Verilator build and run for the execute unit testbench
VERILATOR ?= verilator
TOP       ?= execUnitTb
FILE_LIST ?= files.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_TEXT ?= STATUS: PASS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -o $(TOP) -f $(FILE_LIST)

# Fails unless the pass line shows up in the output
run: compile
	@out="$$(./$(BUILD_DIR)/$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
